//--- sysctl_top.f
+incdir+.
sysctl_pkg.sv
sysctl_dec_if.sv
bus_decode.sv
sysctl_exec.sv
flash_sel_seq.sv
sysctl_top.sv
sysctl_chk.sv
sysctl_monitor.sv
tb_sysctl.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run; pass only if the output holds the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_sysctl -f sysctl_top.f
out=$(./obj_dir/Vtb_sysctl || true)
echo "$out"
if echo "$out" | grep -q "TB PASSED"; then
	exit 0
fi
exit 1

//--- tb_sysctl.sv
/* Testbench for the system-control slice. Random stimulus from a fixed
   xorshift seed; the reload test runs last since PROGRAMN stays low. */
`timescale 1ns/1ns
`include "sysctl_consts.svh"

module tb_sysctl;

	localparam int TOTAL_REQ   = 200 + 30 + 40 + 150 + 2 + 1;
	localparam int TIMEOUT_CYC = TOTAL_REQ * 8 + 500;

	logic               clk48m;
	logic               rst;
	logic               req_valid_i;
	logic               req_ready_o;
	sysctl_pkg::word_t  req_addr_i;
	sysctl_pkg::word_t  req_wdata_i;
	sysctl_pkg::strb_t  req_wstrb_i;
	logic               rsp_valid_o;
	logic               rsp_ready_i;
	sysctl_pkg::word_t  rsp_rdata_o;
	logic               rsp_err_o;
	logic [7:0]         btn_i;
	sysctl_pkg::genio_t genio_in_i;
	logic [8:0]         led_o;
	sysctl_pkg::genio_t genio_out_o;
	sysctl_pkg::genio_t genio_oe_o;
	logic               fsel_c_o;
	logic               fsel_d_o;
	logic               programn_o;
	logic               trace_en_o;
	logic               bus_error_irq_o;

	logic [31:0] rng = 32'h8d669f28;
	logic        stall_en = 1'b0;
	int          sent = 0;
	int          cyc_cnt = 0;

	sysctl_top i_sysctl_top (.*);

	sysctl_monitor i_monitor (
		.clk48m (clk48m), .rst (rst),
		.req_valid_i (req_valid_i), .req_ready_i (req_ready_o),
		.req_addr_i (req_addr_i), .req_wdata_i (req_wdata_i), .req_wstrb_i (req_wstrb_i),
		.rsp_valid_i (rsp_valid_o), .rsp_ready_i (rsp_ready_i),
		.rsp_rdata_i (rsp_rdata_o), .rsp_err_i (rsp_err_o),
		.btn_i (btn_i), .genio_in_i (genio_in_i), .led_i (led_o),
		.genio_out_i (genio_out_o), .genio_oe_i (genio_oe_o),
		.fsel_c_i (fsel_c_o), .fsel_d_i (fsel_d_o), .programn_i (programn_o),
		.trace_en_i (trace_en_o), .bus_error_irq_i (bus_error_irq_o)
	);

	initial begin
		clk48m = 1'b0;
		forever #50 clk48m = ~clk48m;
	end

	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ------------------------------
	// bus driving
	// ------------------------------
	task automatic tick();
		@(negedge clk48m);
		rsp_ready_i = stall_en ? (next_rand() % 4 != 0) : 1'b1;
	endtask

	task automatic send(input sysctl_pkg::word_t addr, input sysctl_pkg::word_t data,
			input sysctl_pkg::strb_t strb);
		int gap;
		gap = stall_en ? int'(next_rand() % 3) : 0;
		repeat (gap) tick();
		tick();
		req_valid_i = 1'b1;
		req_addr_i  = addr;
		req_wdata_i = data;
		req_wstrb_i = strb;
		sent++;
		do tick(); while (i_monitor.req_cnt < sent);
		req_valid_i = 1'b0;
	endtask

	task automatic drain();
		do tick(); while (i_monitor.rsp_cnt < sent);
		repeat (3) tick();
	endtask

	function sysctl_pkg::word_t misc_addr(input logic [4:0] idx);
		logic [31:0] r;
		r = next_rand();
		return {`SYSCTL_REGION_MISC, r[27:7], idx, 2'b00};
	endfunction

	function sysctl_pkg::strb_t pick_strb();
		logic [31:0] r;
		r = next_rand();
		case (r % 5)
			0, 1: return 4'h0;
			2: return 4'hf;
			3: return 4'h1;
			default: return (r[7:5] == 3'b000) ? 4'b0010 : {r[7:5], 1'b0};
		endcase
	endfunction

	task automatic rand_access(input logic with_unmapped);
		logic [31:0] r;
		logic [4:0]  idx;
		sysctl_pkg::word_t addr;
		r = next_rand();
		case (r[10:8] % 6)
			0: idx = `SYSCTL_REG_LED;
			1: idx = `SYSCTL_REG_SOC_VER;
			2: idx = `SYSCTL_REG_GENIO_OUT;
			3: idx = `SYSCTL_REG_GENIO_OE;
			4: idx = `SYSCTL_REG_GENIO_W2S;
			default: idx = `SYSCTL_REG_GENIO_W2C;
		endcase
		addr = misc_addr(idx);
		if (with_unmapped && r[3:0] < 5) begin
			addr[31:28] = (r[31:28] == `SYSCTL_REGION_MISC) ? 4'h7 : r[31:28];
		end
		send(addr, next_rand(), pick_strb());
	endtask

	initial begin
		logic [31:0] r;
		rst = 1'b1;
		req_valid_i = 1'b0;
		req_addr_i = '0;
		req_wdata_i = '0;
		req_wstrb_i = '0;
		rsp_ready_i = 1'b1;
		btn_i = 8'h00;
		genio_in_i = '0;
		repeat (8) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;

		i_monitor.test_name = "reg_rw";
		repeat (200) rand_access(1'b0);
		drain();

		i_monitor.test_name = "inputs";
		repeat (3) begin
			r          = next_rand();
			btn_i      = r[7:0];
			r          = next_rand();
			genio_in_i = r[29:0];
			repeat (10) begin
				r = next_rand();
				case (r % 5)
					0: send(misc_addr(`SYSCTL_REG_BTN), 32'h0, 4'h0);
					1: send(misc_addr(`SYSCTL_REG_GENIO_IN), 32'h0, 4'h0);
					2: send(misc_addr(5'd5), 32'h0, 4'h0);
					3: send(misc_addr(5'd9), 32'h0, 4'h0);
					default: send(misc_addr(5'd31), 32'h0, 4'h0);
				endcase
			end
			drain();
		end

		i_monitor.test_name = "unmapped";
		repeat (40) rand_access(1'b1);
		drain();

		i_monitor.test_name = "stall";
		stall_en = 1'b1;
		repeat (150) rand_access(1'b1);
		drain();
		stall_en = 1'b0;
		drain();

		i_monitor.test_name = "flash_sel";
		send(misc_addr(`SYSCTL_REG_FLASH_SEL), 32'h0000_0001, 4'hf);
		drain();
		repeat (12) tick();
		send(misc_addr(`SYSCTL_REG_FLASH_SEL), 32'h0, 4'h0);
		drain();

		i_monitor.test_name = "reload";
		send(misc_addr(`SYSCTL_REG_FLASH_SEL), {`SYSCTL_RELOAD_KEY, 8'h00}, 4'hf);
		drain();
		repeat (15) tick();

		i_monitor.check_counts(sent);
		$display("requests %0d, responses %0d, errors %0d",
			i_monitor.req_cnt, i_monitor.rsp_cnt, i_monitor.err_cnt);
		if (i_monitor.err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// run limit
	initial begin
		while (cyc_cnt <= TIMEOUT_CYC) begin
			@(posedge clk48m);
			cyc_cnt++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- sysctl_monitor.sv
/* Reference model of the misc register bank. Flash-select timing is only
   checked for writes issued with an empty pipeline and no response stall. */
`timescale 1ns/1ns
`include "sysctl_consts.svh"

module sysctl_monitor (
	input logic               clk48m,
	input logic               rst,
	input logic               req_valid_i,
	input logic               req_ready_i,
	input sysctl_pkg::word_t  req_addr_i,
	input sysctl_pkg::word_t  req_wdata_i,
	input sysctl_pkg::strb_t  req_wstrb_i,
	input logic               rsp_valid_i,
	input logic               rsp_ready_i,
	input sysctl_pkg::word_t  rsp_rdata_i,
	input logic               rsp_err_i,
	input logic [7:0]         btn_i,
	input sysctl_pkg::genio_t genio_in_i,
	input logic [8:0]         led_i,
	input sysctl_pkg::genio_t genio_out_i,
	input sysctl_pkg::genio_t genio_oe_i,
	input logic               fsel_c_i,
	input logic               fsel_d_i,
	input logic               programn_i,
	input logic               trace_en_i,
	input logic               bus_error_irq_i
);

	string                test_name = "reset";
	int                   err_cnt = 0;
	int                   req_cnt = 0;
	int                   rsp_cnt = 0;
	int                   irq_cnt = 0;
	int                   exp_irq_cnt = 0;
	int                   cyc = 0;
	int                   sel_cyc = 0;
	logic                 sel_seen = 1'b0;
	logic                 armed = 1'b0;
	sysctl_pkg::word_t    exp_rdata_q[$];
	logic                 exp_err_q[$];
	sysctl_pkg::led_reg_t m_led;
	sysctl_pkg::genio_t   m_out;
	sysctl_pkg::genio_t   m_oe;
	logic                 m_fsel_d;
	logic                 m_trace;

	task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
			err_cnt++;
		end
	endtask

	// ------------------------------
	// model of one accepted request
	// ------------------------------
	task automatic model_access();
		logic [4:0]        idx;
		sysctl_pkg::word_t rd;
		logic              err;
		idx = req_addr_i[6:2];
		rd  = '0;
		err = 1'b0;
		if (req_addr_i[31:28] != `SYSCTL_REGION_MISC) begin
			rd  = `SYSCTL_BUS_ERR_DATA;
			err = 1'b1;
			exp_irq_cnt++;
		end else if (req_wstrb_i == 4'h0) begin
			if (idx == `SYSCTL_REG_LED) rd = {16'h0, m_led};
			else if (idx == `SYSCTL_REG_BTN) rd = {24'h0, ~btn_i};
			else if (idx == `SYSCTL_REG_SOC_VER) rd = `SYSCTL_SOC_VERSION;
			else if (idx == `SYSCTL_REG_FLASH_SEL) rd = {31'h0, m_fsel_d};
			else if (idx == `SYSCTL_REG_GENIO_IN) rd = {2'b00, genio_in_i};
			else if (idx == `SYSCTL_REG_GENIO_OUT) rd = {2'b00, m_out};
			else if (idx == `SYSCTL_REG_GENIO_OE) rd = {2'b00, m_oe};
		end else if (req_wstrb_i[0]) begin
			if (idx == `SYSCTL_REG_LED) m_led = req_wdata_i[15:0];
			else if (idx == `SYSCTL_REG_SOC_VER) m_trace = req_wdata_i[0];
			else if (idx == `SYSCTL_REG_GENIO_OUT) m_out = req_wdata_i[29:0];
			else if (idx == `SYSCTL_REG_GENIO_OE) m_oe = req_wdata_i[29:0];
			else if (idx == `SYSCTL_REG_GENIO_W2S) m_out = m_out | req_wdata_i[29:0];
			else if (idx == `SYSCTL_REG_GENIO_W2C) m_out = m_out & ~req_wdata_i[29:0];
			else if (idx == `SYSCTL_REG_FLASH_SEL) begin
				m_fsel_d = req_wdata_i[0];
				sel_seen = 1'b1;
				sel_cyc  = cyc;
				if (req_wdata_i[31:8] == `SYSCTL_RELOAD_KEY) armed = 1'b1;
			end
		end
		exp_rdata_q.push_back(rd);
		exp_err_q.push_back(err);
	endtask

	// ------------------------------
	// end of run totals
	// ------------------------------
	task automatic check_counts(input int sent_cnt);
		if (req_cnt != sent_cnt || rsp_cnt != sent_cnt) begin
			$display("%0d requests sent but %0d accepted and %0d answered",
				sent_cnt, req_cnt, rsp_cnt);
			err_cnt++;
		end
		if (irq_cnt != exp_irq_cnt) begin
			$display("FAIL %s irq pulses: expected %0d, actual %0d", "unmapped",
				exp_irq_cnt, irq_cnt);
			err_cnt++;
		end
	endtask

	always @(posedge clk48m) begin
		int d;
		if (rst) begin
			m_led    = '0;
			m_out    = '0;
			m_oe     = '0;
			m_fsel_d = 1'b0;
			m_trace  = 1'b0;
		end else begin
			cyc++;
			// pins only once every accepted write has gone through
			if (exp_rdata_q.size() == 0 && !rsp_valid_i) begin
				check("led_o", 32'({m_led[10:8], m_led[5:0]}), 32'(led_i));
				check("genio_out_o", 32'(m_out), 32'(genio_out_i));
				check("genio_oe_o", 32'(m_oe), 32'(genio_oe_i));
				check("trace_en_o", 32'(m_trace), 32'(trace_en_i));
				check("fsel_d_o", 32'(m_fsel_d), 32'(fsel_d_i));
			end
			// values seen here were set by the previous edge
			d = cyc - sel_cyc;
			check("fsel_c_o", 32'(sel_seen && d >= 5 && d <= 7), 32'(fsel_c_i));
			check("programn_o", 32'(!(armed && d >= 9)), 32'(programn_i));
			if (bus_error_irq_i) irq_cnt++;
			if (rsp_valid_i && rsp_ready_i) begin
				rsp_cnt++;
				if (exp_rdata_q.size() == 0) begin
					$display("response %0d arrived with no request outstanding", rsp_cnt);
					err_cnt++;
				end else begin
					check("rsp_rdata_o", exp_rdata_q.pop_front(), rsp_rdata_i);
					check("rsp_err_o", 32'(exp_err_q.pop_front()), 32'(rsp_err_i));
				end
			end
			if (req_valid_i && req_ready_i) begin
				req_cnt++;
				model_access();
			end
		end
	end

endmodule

//--- sysctl_chk.sv
/* Bound assertions on the top-level ports of the system-control slice.
   Needs a simulator run with assertions enabled. */
`timescale 1ns/1ns

module sysctl_chk (
	input logic              clk48m,
	input logic              rst,
	input logic              req_valid_i,
	input logic              req_ready_o,
	input sysctl_pkg::word_t req_addr_i,
	input sysctl_pkg::word_t req_wdata_i,
	input sysctl_pkg::strb_t req_wstrb_i,
	input logic              rsp_valid_o,
	input logic              rsp_ready_i,
	input sysctl_pkg::word_t rsp_rdata_o,
	input logic              rsp_err_o,
	input logic              fsel_c_o,
	input logic              programn_o
);

	// request held by the master until accepted
	a_req_stable: assert property (@(posedge clk48m) disable iff (rst)
		req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_addr_i)
			&& $stable(req_wdata_i) && $stable(req_wstrb_i))
		else $error("request changed while stalled");

	// response held by the DUT until taken
	a_rsp_stable: assert property (@(posedge clk48m) disable iff (rst)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o)
			&& $stable(rsp_err_o))
		else $error("response changed while stalled");

	a_fsel_c_len: assert property (@(posedge clk48m) disable iff (rst)
		fsel_c_o [*3] |=> !fsel_c_o)
		else $error("flash select clock high for more than three cycles");

	a_programn_low: assert property (@(posedge clk48m) disable iff (rst)
		!programn_o |=> !programn_o)
		else $error("programn rose again without reset");

endmodule

bind sysctl_top sysctl_chk i_sysctl_chk (
	.clk48m      (clk48m),
	.rst         (rst),
	.req_valid_i (req_valid_i),
	.req_ready_o (req_ready_o),
	.req_addr_i  (req_addr_i),
	.req_wdata_i (req_wdata_i),
	.req_wstrb_i (req_wstrb_i),
	.rsp_valid_o (rsp_valid_o),
	.rsp_ready_i (rsp_ready_i),
	.rsp_rdata_o (rsp_rdata_o),
	.rsp_err_o   (rsp_err_o),
	.fsel_c_o    (fsel_c_o),
	.programn_o  (programn_o)
);

//--- sysctl_top.sv
/* System-control slice: decode and execute stages plus flash-select sequencer.
   Two accesses in flight at most; responses return in request order. */
`timescale 1ns/1ns

module sysctl_top (
	input  logic               clk48m,
	input  logic               rst,
	// request channel
	input  logic               req_valid_i,
	output logic               req_ready_o,
	input  sysctl_pkg::word_t  req_addr_i,
	input  sysctl_pkg::word_t  req_wdata_i,
	input  sysctl_pkg::strb_t  req_wstrb_i,
	// response channel
	output logic               rsp_valid_o,
	input  logic               rsp_ready_i,
	output sysctl_pkg::word_t  rsp_rdata_o,
	output logic               rsp_err_o,
	// board pins
	input  logic [7:0]         btn_i,
	input  sysctl_pkg::genio_t genio_in_i,
	output logic [8:0]         led_o,
	output sysctl_pkg::genio_t genio_out_o,
	output sysctl_pkg::genio_t genio_oe_o,
	output logic               fsel_c_o,
	output logic               fsel_d_o,
	output logic               programn_o,
	output logic               trace_en_o,
	output logic               bus_error_irq_o
);

	logic sel_strobe;
	logic reload_arm;

	sysctl_dec_if i_dec_if ();

	bus_decode i_bus_decode (
		.clk48m      (clk48m),
		.rst         (rst),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.req_wstrb_i (req_wstrb_i),
		.dec         (i_dec_if.src)
	);

	sysctl_exec i_sysctl_exec (
		.clk48m          (clk48m),
		.rst             (rst),
		.dec             (i_dec_if.dst),
		.btn_i           (btn_i),
		.genio_in_i      (genio_in_i),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_ready_i     (rsp_ready_i),
		.rsp_rdata_o     (rsp_rdata_o),
		.rsp_err_o       (rsp_err_o),
		.led_o           (led_o),
		.genio_out_o     (genio_out_o),
		.genio_oe_o      (genio_oe_o),
		.fsel_d_o        (fsel_d_o),
		.trace_en_o      (trace_en_o),
		.bus_error_irq_o (bus_error_irq_o),
		.sel_strobe_o    (sel_strobe),
		.reload_arm_o    (reload_arm)
	);

	flash_sel_seq i_flash_sel_seq (
		.clk48m       (clk48m),
		.rst          (rst),
		.sel_strobe_i (sel_strobe),
		.reload_arm_i (reload_arm),
		.fsel_c_o     (fsel_c_o),
		.programn_o   (programn_o)
	);

endmodule

//--- flash_sel_seq.sv
/* Clock pulse for the flash mux flip-flop and PROGRAMN sequencing.
   Once pulled low, PROGRAMN stays low until reset. */
`timescale 1ns/1ns
`include "sysctl_consts.svh"

module flash_sel_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic sel_strobe_i,
	input  logic reload_arm_i,
	output logic fsel_c_o,
	output logic programn_o
);

	sysctl_pkg::sel_cnt_t sel_cnt;
	logic                 reload_pend;
	logic                 reload_q;
	logic                 fsel_c_q;

	// ------------------------------
	// delay counter
	// ------------------------------
	// the data bit settles on the mux input before the clock edge, and the
	// clock pulse is over well before PROGRAMN drops
	always_ff @(posedge clk48m) begin
		if (rst) begin
			sel_cnt     <= '0;
			reload_pend <= 1'b0;
			reload_q    <= 1'b0;
			fsel_c_q    <= 1'b0;
		end else begin
			// registered so the flash mux sees a clean clock
			fsel_c_q <= (sel_cnt >= 3'd3) && (sel_cnt <= 3'd5);
			if (reload_arm_i) begin
				reload_pend <= 1'b1;
			end
			if (sel_strobe_i) begin
				sel_cnt <= `SYSCTL_FSEL_DELAY;
			end else if (sel_cnt != '0) begin
				sel_cnt <= sel_cnt - 3'd1;
				if (sel_cnt == 3'd1 && reload_pend) begin
					reload_q <= 1'b1;
				end
			end
		end
	end

	assign fsel_c_o   = fsel_c_q;
	assign programn_o = !reload_q;

endmodule

//--- sysctl_exec.sv
/* Second pipeline stage: misc register bank and response register.
   Reads return the value before a write on the same edge; writes answer zero. */
`timescale 1ns/1ns
`include "sysctl_consts.svh"

module sysctl_exec (
	input  logic               clk48m,
	input  logic               rst,
	sysctl_dec_if.dst          dec,
	input  logic [7:0]         btn_i,
	input  sysctl_pkg::genio_t genio_in_i,
	output logic               rsp_valid_o,
	input  logic               rsp_ready_i,
	output sysctl_pkg::word_t  rsp_rdata_o,
	output logic               rsp_err_o,
	output logic [8:0]         led_o,
	output sysctl_pkg::genio_t genio_out_o,
	output sysctl_pkg::genio_t genio_oe_o,
	output logic               fsel_d_o,
	output logic               trace_en_o,
	output logic               bus_error_irq_o,
	output logic               sel_strobe_o,
	output logic               reload_arm_o
);

	logic                 item_fire;
	logic                 is_misc;
	logic                 misc_wr;
	sysctl_pkg::word_t    rdata_d;
	sysctl_pkg::led_reg_t led_q;
	sysctl_pkg::genio_t   genio_out_q;
	sysctl_pkg::genio_t   genio_oe_q;
	logic                 fsel_d_q;
	logic                 trace_en_q;
	logic                 rsp_valid_q;
	logic                 rsp_err_q;
	sysctl_pkg::word_t    rsp_rdata_q;
	logic                 irq_q;

	// execute stalls only while a response is held
	assign dec.ready = !rsp_valid_q || rsp_ready_i;
	assign item_fire = dec.valid && dec.ready;
	assign is_misc   = (dec.region == sysctl_pkg::REGION_MISC);
	assign misc_wr   = item_fire && is_misc && dec.wr_en;

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		rdata_d = '0;
		if (!is_misc) begin
			rdata_d = `SYSCTL_BUS_ERR_DATA;
		end else if (!dec.wr_en) begin
			case (dec.reg_idx)
				`SYSCTL_REG_LED: begin
					rdata_d = {16'h0, led_q};
				end
				`SYSCTL_REG_BTN: begin
					// buttons are active low on the board
					rdata_d = {24'h0, ~btn_i};
				end
				`SYSCTL_REG_SOC_VER: begin
					rdata_d = `SYSCTL_SOC_VERSION;
				end
				`SYSCTL_REG_FLASH_SEL: begin
					rdata_d = {31'h0, fsel_d_q};
				end
				`SYSCTL_REG_GENIO_IN: begin
					rdata_d = {2'b00, genio_in_i};
				end
				`SYSCTL_REG_GENIO_OUT: begin
					rdata_d = {2'b00, genio_out_q};
				end
				`SYSCTL_REG_GENIO_OE: begin
					rdata_d = {2'b00, genio_oe_q};
				end
				default: begin
					rdata_d = '0;
				end
			endcase
		end
	end

	// ------------------------------
	// register bank
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_q       <= '0;
			genio_out_q <= '0;
			genio_oe_q  <= '0;
			fsel_d_q    <= 1'b0;
			trace_en_q  <= 1'b0;
		end else if (misc_wr) begin
			case (dec.reg_idx)
				`SYSCTL_REG_LED: begin
					led_q <= dec.wdata[15:0];
				end
				`SYSCTL_REG_SOC_VER: begin
					// version is read-only, bit 0 of a write controls trace
					trace_en_q <= dec.wdata[0];
				end
				`SYSCTL_REG_FLASH_SEL: begin
					fsel_d_q <= dec.wdata[0];
				end
				`SYSCTL_REG_GENIO_OUT: begin
					genio_out_q <= dec.wdata[29:0];
				end
				`SYSCTL_REG_GENIO_OE: begin
					genio_oe_q <= dec.wdata[29:0];
				end
				`SYSCTL_REG_GENIO_W2S: begin
					genio_out_q <= genio_out_q | dec.wdata[29:0];
				end
				`SYSCTL_REG_GENIO_W2C: begin
					genio_out_q <= genio_out_q & ~dec.wdata[29:0];
				end
				default: begin
				end
			endcase
		end
	end

	// flash-select side effects, same cycle as the accepted write
	assign sel_strobe_o = misc_wr && (dec.reg_idx == `SYSCTL_REG_FLASH_SEL);
	assign reload_arm_o = sel_strobe_o && (dec.wdata[31:8] == `SYSCTL_RELOAD_KEY);

	// ------------------------------
	// response register
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			rsp_valid_q <= 1'b0;
			irq_q       <= 1'b0;
		end else begin
			// one pulse per accepted unmapped access
			irq_q <= item_fire && !is_misc;
			if (item_fire) begin
				rsp_valid_q <= 1'b1;
			end else if (rsp_ready_i) begin
				rsp_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk48m) begin
		if (item_fire) begin
			rsp_rdata_q <= rdata_d;
			rsp_err_q   <= !is_misc;
		end
	end

	assign rsp_valid_o     = rsp_valid_q;
	assign rsp_rdata_o     = rsp_rdata_q;
	assign rsp_err_o       = rsp_err_q;
	assign bus_error_irq_o = irq_q;

	// LED pins 8:6 come from register bits 10:8
	assign led_o       = {led_q[10:8], led_q[5:0]};
	assign genio_out_o = genio_out_q;
	assign genio_oe_o  = genio_oe_q;
	assign fsel_d_o    = fsel_d_q;
	assign trace_en_o  = trace_en_q;

endmodule

//--- bus_decode.sv
/* First pipeline stage with a single request slot. A write whose strobe
   misses byte 0 is steered to a spare index so it reads back zero and writes nothing. */
`timescale 1ns/1ns
`include "sysctl_consts.svh"

module bus_decode (
	input  logic               clk48m,
	input  logic               rst,
	input  logic               req_valid_i,
	output logic               req_ready_o,
	input  sysctl_pkg::word_t  req_addr_i,
	input  sysctl_pkg::word_t  req_wdata_i,
	input  sysctl_pkg::strb_t  req_wstrb_i,
	sysctl_dec_if.src          dec
);

	logic                 slot_full;
	logic                 req_fire;
	sysctl_pkg::region_e  region_d;
	sysctl_pkg::reg_idx_t idx_d;
	sysctl_pkg::region_e  region_q;
	sysctl_pkg::reg_idx_t idx_q;
	logic                 wr_en_q;
	sysctl_pkg::word_t    wdata_q;

	// slot can take a new request when empty or when it drains this cycle
	assign req_ready_o = !slot_full || dec.ready;
	assign req_fire    = req_valid_i && req_ready_o;

	// ------------------------------
	// address classification
	// ------------------------------
	always_comb begin
		if (req_addr_i[31:28] == `SYSCTL_REGION_MISC) begin
			region_d = sysctl_pkg::REGION_MISC;
		end else begin
			region_d = sysctl_pkg::REGION_UNMAPPED;
		end
		idx_d = req_addr_i[6:2];
		// partial write without byte 0, answered as a write with no effect
		if (req_wstrb_i != '0 && !req_wstrb_i[0]) begin
			idx_d = `SYSCTL_REG_SPARE;
		end
	end

	// ------------------------------
	// request slot
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			slot_full <= 1'b0;
		end else if (req_fire) begin
			slot_full <= 1'b1;
		end else if (dec.ready) begin
			slot_full <= 1'b0;
		end
	end

	always_ff @(posedge clk48m) begin
		if (req_fire) begin
			region_q <= region_d;
			idx_q    <= idx_d;
			wr_en_q  <= req_wstrb_i[0];
			wdata_q  <= req_wdata_i;
		end
	end

	assign dec.valid   = slot_full;
	assign dec.region  = region_q;
	assign dec.reg_idx = idx_q;
	assign dec.wr_en   = wr_en_q;
	assign dec.wdata   = wdata_q;

endmodule

//--- sysctl_dec_if.sv
/* Decoded access from the decode stage to the execute stage.
   valid/ready handshake; payload is stable while valid is high and ready low. */
`timescale 1ns/1ns

interface sysctl_dec_if;

	logic                 valid;
	logic                 ready;
	sysctl_pkg::region_e  region;
	sysctl_pkg::reg_idx_t reg_idx;
	// high only when byte 0 is written
	logic                 wr_en;
	sysctl_pkg::word_t    wdata;

	modport src (
		output valid,
		output region,
		output reg_idx,
		output wr_en,
		output wdata,
		input  ready
	);

	modport dst (
		input  valid,
		input  region,
		input  reg_idx,
		input  wr_en,
		input  wdata,
		output ready
	);

endinterface

//--- sysctl_pkg.sv
/* Shared types of the system-control slice. Widths follow the fixed
   register map and are not meant to be changed. */
package sysctl_pkg;

	// bus data or address word
	typedef logic [31:0] word_t;

	// byte write strobes
	typedef logic [3:0] strb_t;

	// word index inside the misc region, address bits 6:2
	typedef logic [4:0] reg_idx_t;

	// general I/O vector
	typedef logic [29:0] genio_t;

	// LED register contents
	typedef logic [15:0] led_reg_t;

	// flash-select delay counter
	typedef logic [2:0] sel_cnt_t;

	// address region seen by the execute stage
	typedef enum bit [0:0] {
		REGION_MISC     = 1'b0,
		REGION_UNMAPPED = 1'b1
	} region_e;

endpackage

//--- sysctl_consts.svh
/* Register map constants for the misc region. Index values are 5-bit word
   offsets taken from address bits 6:2; all other indices in the region read zero. */
`ifndef SYSCTL_CONSTS_SVH
`define SYSCTL_CONSTS_SVH

// ------------------------------
// address decode
// ------------------------------
// upper address nibble of the misc region
`define SYSCTL_REGION_MISC     4'h2

// ------------------------------
// register indices
// ------------------------------
`define SYSCTL_REG_LED         5'd0
`define SYSCTL_REG_BTN         5'd1
`define SYSCTL_REG_SOC_VER     5'd2
`define SYSCTL_REG_FLASH_SEL   5'd13
`define SYSCTL_REG_GENIO_IN    5'd17
`define SYSCTL_REG_GENIO_OUT   5'd18
`define SYSCTL_REG_GENIO_OE    5'd19
`define SYSCTL_REG_GENIO_W2S   5'd20
`define SYSCTL_REG_GENIO_W2C   5'd21
// spare index, reads zero and has no register behind it
`define SYSCTL_REG_SPARE       5'd31

// ------------------------------
// data words
// ------------------------------
`define SYSCTL_SOC_VERSION     32'h0000_0000
`define SYSCTL_BUS_ERR_DATA    32'hDEAD_BEEF
// key in write data bits 31:8 of a flash-select write that arms an FPGA reload
`define SYSCTL_RELOAD_KEY      24'hD0F1A5
// flash-select counter load value
`define SYSCTL_FSEL_DELAY      3'd7

`endif
